//--- logic/i2c_led_pkg.sv
// shared types for the I2C LED target
// the decoder produces the event word and the target FSM consumes it
package i2c_led_pkg;

	// width of a 7-bit I2C target address
	localparam int ADDR_W = 7;

	// one word of bus events, rebuilt every clock by the decoder
	// every field except sda is a single-cycle strobe
	typedef struct packed {
		// SDA fell while SCL was high, a start or repeated start
		logic start;
		// SDA rose while SCL was high
		logic stop;
		// SCL went from low to high, the moment data is sampled
		logic scl_rise;
		// SCL went from high to low, the moment the target may change SDA
		logic scl_fall;
		// filtered SDA level, registered alongside the strobes
		logic sda;
	} bus_event_t;

	// states of the target FSM
	typedef enum logic [2:0] {
		// waiting for a start
		st_idle,
		// shifting in the address and the read/write bit
		st_addr,
		// pulling SDA low for the address acknowledge
		st_addr_ack,
		// shifting in a write byte
		st_wr_data,
		// pulling SDA low for a write byte acknowledge
		st_wr_ack,
		// shifting out the LED byte
		st_rd_data,
		// SDA released while the controller acknowledges
		st_rd_ack,
		// another target was addressed, sit out until start or stop
		st_ignore
	} target_state_t;

endpackage

//--- logic/line_filter.sv
`timescale 1ns/1ps

// glitch filter for one bus line
// the line is synchronised with two flops, then a change is only accepted once the
// synchronised level has differed from the output for FILTER_DEPTH samples in a row
module line_filter #(
	parameter int FILTER_DEPTH = 4
) (
	input  logic CLK,
	input  logic rst_n,
	input  logic line_in,
	output logic line_out
);

	// wide enough to hold FILTER_DEPTH itself
	localparam int CNT_W = $clog2(FILTER_DEPTH + 1);

	// sync_q[0] may go metastable, sync_q[1] is the settled sample
	logic [1:0] sync_q;
	// number of consecutive samples that disagree with line_out
	logic [CNT_W-1:0] diff_cnt;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			// an idle I2C line is pulled high
			sync_q   <= 2'b11;
			diff_cnt <= '0;
			line_out <= 1'b1;
		end else begin
			sync_q <= {sync_q[0], line_in};
			if (sync_q[1] == line_out) begin
				// any agreeing sample throws away the count so far
				diff_cnt <= '0;
			end else if (diff_cnt == CNT_W'(FILTER_DEPTH - 1)) begin
				// this is the FILTER_DEPTH-th differing sample, so accept it
				line_out <= sync_q[1];
				diff_cnt <= '0;
			end else begin
				diff_cnt <= diff_cnt + 1'b1;
			end
		end
	end

endmodule

//--- logic/bus_event_decode.sv
`timescale 1ns/1ps

// turns the filtered SCL and SDA levels into one-cycle bus event strobes
// all strobes are registered, so each one is high during the cycle after the
// filtered level changed
module bus_event_decode import i2c_led_pkg::*; (
	input  logic       CLK,
	input  logic       rst_n,
	input  logic       scl,
	input  logic       sda,
	output bus_event_t bus_ev
);

	// levels seen on the previous clock
	logic scl_q;
	logic sda_q;

	// edge detection on the raw filtered levels
	logic scl_high_both;
	logic sda_fell;
	logic sda_rose;

	// SCL must be high now and on the previous sample for SDA edges to count as
	// start or stop, which keeps them apart from the SCL edge strobes
	assign scl_high_both = scl & scl_q;
	assign sda_fell      = sda_q & ~sda;
	assign sda_rose      = ~sda_q & sda;

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			// both lines idle high, so nothing looks like an edge after reset
			scl_q  <= 1'b1;
			sda_q  <= 1'b1;
			bus_ev <= '{start: 1'b0, stop: 1'b0, scl_rise: 1'b0, scl_fall: 1'b0,
				sda: 1'b1};
		end else begin
			scl_q <= scl;
			sda_q <= sda;

			// start is SDA going low with SCL held high
			bus_ev.start <= scl_high_both & sda_fell;
			// stop is SDA going high with SCL held high
			bus_ev.stop  <= scl_high_both & sda_rose;

			// clock edges, used by the FSM for sampling and for driving
			bus_ev.scl_rise <= scl & ~scl_q;
			bus_ev.scl_fall <= ~scl & scl_q;

			// the level travels with the strobes so that the FSM samples SDA as it
			// stood on the same clock the SCL rise was seen
			bus_ev.sda <= sda;
		end
	end

	// the two SDA edge cases can never both be true in one cycle, and neither
	// can coincide with an SCL edge because scl_high_both needs SCL stable high
	// so at most one strobe in bus_ev is ever set

endmodule

//--- logic/i2c_target_fsm.sv
`timescale 1ns/1ps

// I2C target FSM
// matches the 7-bit address, takes write bytes into the LED register and
// shifts the LED register back out on reads
// SDA is only ever pulled low, and only on the cycle after an scl_fall strobe
module i2c_target_fsm import i2c_led_pkg::*; #(
	parameter logic [ADDR_W-1:0] TARGET_ADDR = 7'h27
) (
	input  logic       CLK,
	input  logic       rst_n,
	input  bus_event_t bus_ev,
	output logic       sda_drive_low,
	output logic [7:0] led
);

	target_state_t state;

	// incoming bits are shifted in at the bottom, outgoing bits leave at the top
	logic [7:0] shift_q;
	// counts SCL rises within a byte and wraps to zero after the eighth
	logic [2:0] bit_cnt;
	// set for the ninth clock of a byte, the acknowledge slot
	logic       ack_phase;
	// read/write bit taken from the address byte, high means read
	logic       read_q;

	// the bit completing the current byte arrives on this rise
	logic last_bit;
	// byte as it stands once the bit on the current rise is shifted in
	logic [7:0] byte_in;

	assign last_bit = (bit_cnt == 3'd7);
	assign byte_in  = {shift_q[6:0], bus_ev.sda};

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			state         <= st_idle;
			shift_q       <= '0;
			bit_cnt       <= '0;
			ack_phase     <= 1'b0;
			read_q        <= 1'b0;
			sda_drive_low <= 1'b0;
			led           <= '0;
		end else if (bus_ev.stop) begin
			// a stop ends any transfer, even one meant for another target
			state         <= st_idle;
			ack_phase     <= 1'b0;
			sda_drive_low <= 1'b0;
		end else if (bus_ev.start) begin
			// start and repeated start both begin a fresh address byte
			// SDA is already released here, since a start needs SDA high
			// just before it
			state         <= st_addr;
			bit_cnt       <= '0;
			ack_phase     <= 1'b0;
			sda_drive_low <= 1'b0;
		end else begin
			case (state)
				st_addr: begin
					if (bus_ev.scl_rise) begin
						shift_q <= byte_in;
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit) begin
							// the seven address bits are already in shift_q and
							// the bit on this rise is read/write
							if (shift_q[ADDR_W-1:0] == TARGET_ADDR) begin
								state  <= st_addr_ack;
								read_q <= bus_ev.sda;
							end else begin
								state <= st_ignore;
							end
						end
					end
				end

				st_addr_ack: begin
					if (bus_ev.scl_fall) begin
						if (!ack_phase) begin
							// end of the eighth clock, hold SDA low for the ACK
							ack_phase     <= 1'b1;
							sda_drive_low <= 1'b1;
						end else if (read_q) begin
							// end of the ACK clock, put out the first read bit
							ack_phase     <= 1'b0;
							state         <= st_rd_data;
							sda_drive_low <= ~led[7];
							shift_q       <= {led[6:0], 1'b0};
						end else begin
							ack_phase     <= 1'b0;
							state         <= st_wr_data;
							sda_drive_low <= 1'b0;
						end
					end
				end

				st_wr_data: begin
					if (bus_ev.scl_rise) begin
						shift_q <= byte_in;
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit) begin
							// the LEDs follow every complete write byte
							led   <= byte_in;
							state <= st_wr_ack;
						end
					end
				end

				st_wr_ack: begin
					if (bus_ev.scl_fall) begin
						if (!ack_phase) begin
							ack_phase     <= 1'b1;
							sda_drive_low <= 1'b1;
						end else begin
							// ACK clock done, let go for the next byte
							ack_phase     <= 1'b0;
							state         <= st_wr_data;
							sda_drive_low <= 1'b0;
						end
					end
				end

				st_rd_data: begin
					// the first bit was set up on entry, so each rise here is the
					// controller sampling a bit we already drive
					if (bus_ev.scl_rise) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (last_bit) begin
							state <= st_rd_ack;
						end
					end else if (bus_ev.scl_fall) begin
						// next bit, MSB first, pull low only for a zero
						sda_drive_low <= ~shift_q[7];
						shift_q       <= {shift_q[6:0], 1'b0};
					end
				end

				st_rd_ack: begin
					if (bus_ev.scl_fall) begin
						if (!ack_phase) begin
							// hand SDA to the controller for its ACK or NACK
							ack_phase     <= 1'b1;
							sda_drive_low <= 1'b0;
						end else begin
							// ACK was seen, send the LED byte once more
							ack_phase     <= 1'b0;
							state         <= st_rd_data;
							sda_drive_low <= ~led[7];
							shift_q       <= {led[6:0], 1'b0};
						end
					end else if (bus_ev.scl_rise && ack_phase && bus_ev.sda) begin
						// NACK, the controller wants no more data
						// SDA is already released so the stop can follow
						ack_phase <= 1'b0;
						state     <= st_idle;
					end
				end

				// idle and ignore only leave on start or stop, handled above
				default: begin
					sda_drive_low <= 1'b0;
				end
			endcase
		end
	end

endmodule

//--- logic/i2c_led_top.sv
`timescale 1ns/1ps

// I2C target that shows the last byte written to it on eight LEDs
// the pad SDA is split into sda_in and sda_drive_low, with the pull-up and the
// open-drain buffer left outside this block
module i2c_led_top import i2c_led_pkg::*; #(
	parameter logic [ADDR_W-1:0] TARGET_ADDR = 7'h27,
	parameter int FILTER_DEPTH = 4
) (
	input  logic       CLK,
	input  logic       rst_n,
	input  logic       scl_in,
	input  logic       sda_in,
	output logic       sda_drive_low,
	output logic [7:0] led
);

	// deglitched bus levels
	logic scl_filt;
	logic sda_filt;

	// start, stop and SCL edge strobes plus the SDA level
	bus_event_t bus_ev;

	// both lines get the same filter so that an SCL edge and an SDA edge
	// arriving together keep their order through the filters
	line_filter #(
		.FILTER_DEPTH(FILTER_DEPTH)
	) scl_filter (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.line_in (scl_in),
		.line_out(scl_filt)
	);

	line_filter #(
		.FILTER_DEPTH(FILTER_DEPTH)
	) sda_filter (
		.CLK     (CLK),
		.rst_n   (rst_n),
		.line_in (sda_in),
		.line_out(sda_filt)
	);

	bus_event_decode event_decode (
		.CLK   (CLK),
		.rst_n (rst_n),
		.scl   (scl_filt),
		.sda   (sda_filt),
		.bus_ev(bus_ev)
	);

	// sda_drive_low lags an input change by at most FILTER_DEPTH+4 clocks
	i2c_target_fsm #(
		.TARGET_ADDR(TARGET_ADDR)
	) target_fsm (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.bus_ev       (bus_ev),
		.sda_drive_low(sda_drive_low),
		.led          (led)
	);

endmodule

//--- tests/i2c_led_asserts.sv
`timescale 1ns/1ps

// protocol checks on the I2C LED target, bound into i2c_led_top
// failed goes high for good once any property has failed
module i2c_led_asserts import i2c_led_pkg::*; (
	input logic          CLK,
	input logic          rst_n,
	input logic          scl_filt,
	input logic          sda_drive_low,
	input logic [7:0]    led,
	input bus_event_t    bus_ev,
	input target_state_t state
);

	logic drive_err = 1'b0;
	logic reset_err = 1'b0;
	logic strobe_err = 1'b0;
	logic owner_err = 1'b0;
	logic failed;

	assign failed = drive_err | reset_err | strobe_err | owner_err;

	// a target may only move SDA while SCL is low
	assert property (@(posedge CLK) disable iff (!rst_n)
		(scl_filt && $past(scl_filt)) |-> $stable(sda_drive_low))
	else begin
		$error("sda_drive_low changed while SCL was high");
		drive_err = 1'b1;
	end

	// outputs sit at zero through reset
	assert property (@(posedge CLK) !rst_n |=> (sda_drive_low == 1'b0 && led == 8'h00))
	else begin
		$error("sda_drive_low or led not zero during reset");
		reset_err = 1'b1;
	end

	// start and stop never coincide with an SCL edge, nor with each other
	assert property (@(posedge CLK) disable iff (!rst_n)
		$onehot0({bus_ev.start, bus_ev.stop, bus_ev.scl_rise, bus_ev.scl_fall}))
	else begin
		$error("more than one bus event strobe high in one cycle");
		strobe_err = 1'b1;
	end

	// SDA is only pulled in the acknowledge and read data states
	assert property (@(posedge CLK) disable iff (!rst_n)
		sda_drive_low |-> state inside {st_addr_ack, st_wr_ack, st_rd_data, st_rd_ack})
	else begin
		$error("SDA pulled low outside an acknowledge or read state");
		owner_err = 1'b1;
	end

endmodule

bind i2c_led_top i2c_led_asserts asserts0 (
	.CLK          (CLK),
	.rst_n        (rst_n),
	.scl_filt     (scl_filt),
	.sda_drive_low(sda_drive_low),
	.led          (led),
	.bus_ev       (bus_ev),
	.state        (target_fsm.state)
);

//--- tests/i2c_led_tb.sv
`timescale 1ns/1ps

// testbench for the I2C LED target
// a controller model drives SCL and its own SDA, and the pad SDA is the
// wired-AND of that and the target's open-drain pull
module i2c_led_tb import i2c_led_pkg::*; ();

	localparam logic [ADDR_W-1:0] TARGET_ADDR = 7'h27;
	localparam int FILTER_DEPTH = 4;
	// SCL half period in CLK cycles
	localparam int HALF = 20;
	localparam int ROUNDS = 3;
	// three rounds of four transactions of about 30 bits at 40 cycles come to
	// roughly 16000 cycles, and the limit leaves close to double that
	localparam int MAX_CYCLES = 30000;

	logic       CLK;
	logic       rst_n;
	logic       scl_in;
	logic       sda_in;
	logic       sda_ctrl;
	logic       sda_drive_low;
	logic [7:0] led;

	logic [31:0] lfsr_q = 32'h8104;
	int          cycle_cnt = 0;
	// high while glitches hit the idle bus and neither the filtered lines nor SDA may move
	logic        quiet_bus = 1'b0;
	// the byte the LEDs should show
	logic [7:0]  led_exp = 8'h00;

	// the pad is pulled up and either side may pull it low
	assign sda_in = sda_ctrl & ~sda_drive_low;

	i2c_led_top #(
		.TARGET_ADDR (TARGET_ADDR),
		.FILTER_DEPTH(FILTER_DEPTH)
	) dut0 (
		.CLK          (CLK),
		.rst_n        (rst_n),
		.scl_in       (scl_in),
		.sda_in       (sda_in),
		.sda_drive_low(sda_drive_low),
		.led          (led)
	);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// 32-bit Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// one LFSR step for every bit taken with the newest bit at the bottom
	task automatic take_bits(input int n, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			value  = {value[30:0], lfsr_q[0]};
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1);
	endtask

	task automatic expect_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else
			abort_run($sformatf("mismatch %s: got 0x%h expected 0x%h", name, got, exp));
	endtask

	task automatic expect_ack(input logic acked, input logic wanted, input string step);
		assert (acked === wanted) else begin
			if (wanted)
				abort_run({"the target gave no acknowledge for ", step});
			else
				abort_run({"the target acknowledged ", step, " although it was not addressed"});
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLK);
	endtask

	// one SCL clock that starts and ends with SCL low
	// SDA moves mid low and is sampled mid high where it is stable
	task automatic clock_bit(input logic bit_out, output logic bit_seen);
		wait_cycles(HALF / 2);
		sda_ctrl <= bit_out;
		wait_cycles(HALF / 2);
		scl_in <= 1'b1;
		wait_cycles(HALF / 2);
		bit_seen = sda_in;
		wait_cycles(HALF / 2);
		scl_in <= 1'b0;
	endtask

	// works from the idle bus and as a repeated start with SCL low
	task automatic start_cond();
		wait_cycles(HALF / 2);
		sda_ctrl <= 1'b1;
		wait_cycles(HALF / 2);
		scl_in <= 1'b1;
		wait_cycles(HALF);
		sda_ctrl <= 1'b0;
		wait_cycles(HALF);
		scl_in <= 1'b0;
	endtask

	task automatic stop_cond();
		wait_cycles(HALF / 2);
		sda_ctrl <= 1'b0;
		wait_cycles(HALF / 2);
		scl_in <= 1'b1;
		wait_cycles(HALF);
		sda_ctrl <= 1'b1;
		wait_cycles(HALF);
	endtask

	// eight bits MSB first and then the ninth clock with SDA released
	task automatic write_byte(input logic [7:0] data, output logic acked);
		logic seen;
		for (int i = 7; i >= 0; i--)
			clock_bit(data[i], seen);
		clock_bit(1'b1, seen);
		acked = !seen;
	endtask

	task automatic read_byte(input logic send_ack, output logic [7:0] data);
		logic seen;
		for (int i = 7; i >= 0; i--) begin
			clock_bit(1'b1, seen);
			data[i] = seen;
		end
		clock_bit(!send_ack, seen);
	endtask

	// short low pulses on either line while the bus idles
	task automatic glitch_idle(input int count);
		logic [31:0] r;
		for (int g = 0; g < count; g++) begin
			// four bits set the gap and the fifth picks the line
			take_bits(5, r);
			wait_cycles(FILTER_DEPTH * 3 + int'(r[3:0]));
			if (r[4])
				scl_in <= 1'b0;
			else
				sda_ctrl <= 1'b0;
			wait_cycles(FILTER_DEPTH - 1);
			scl_in   <= 1'b1;
			sda_ctrl <= 1'b1;
		end
		wait_cycles(HALF);
	endtask

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (dut0.asserts0.failed) begin
			abort_run("a protocol assertion in i2c_led_asserts failed");
		end else if (cycle_cnt >= MAX_CYCLES) begin
			abort_run($sformatf("timeout, the run went past %0d cycles", MAX_CYCLES));
		end else if (quiet_bus) begin
			assert (sda_drive_low == 1'b0) else
				abort_run($sformatf("mismatch sda_drive_low: got 0x%h expected 0x0",
					sda_drive_low));
			// pulses shorter than the filter depth must never reach the filtered lines
			assert (dut0.scl_filt === 1'b1) else
				abort_run($sformatf("mismatch scl_filt: got 0x%h expected 0x1",
					dut0.scl_filt));
			assert (dut0.sda_filt === 1'b1) else
				abort_run($sformatf("mismatch sda_filt: got 0x%h expected 0x1",
					dut0.sda_filt));
		end
	end

	initial begin
		logic [31:0] r;
		logic        acked;
		logic [7:0]  got;
		logic [6:0]  other_addr;
		rst_n    <= 1'b0;
		scl_in   <= 1'b1;
		sda_ctrl <= 1'b1;
		wait_cycles(16);
		rst_n <= 1'b1;
		wait_cycles(HALF);
		expect_byte("led", led, 8'h00);
		expect_byte("sda_drive_low", {7'b0, sda_drive_low}, 8'h00);

		for (int round = 0; round < ROUNDS; round++) begin
			// a write of three random bytes where the LEDs keep the last one
			start_cond();
			write_byte({TARGET_ADDR, 1'b0}, acked);
			expect_ack(acked, 1'b1, "its write address");
			for (int n = 0; n < 3; n++) begin
				take_bits(8, r);
				led_exp = r[7:0];
				write_byte(led_exp, acked);
				expect_ack(acked, 1'b1, "a write data byte");
			end
			stop_cond();
			expect_byte("led", led, led_exp);

			// another target's address is left unanswered
			take_bits(7, r);
			other_addr = r[6:0];
			if (other_addr == TARGET_ADDR)
				other_addr = other_addr ^ 7'h01;
			start_cond();
			write_byte({other_addr, 1'b0}, acked);
			expect_ack(acked, 1'b0, "a foreign address");
			take_bits(8, r);
			write_byte(r[7:0], acked);
			expect_ack(acked, 1'b0, "a data byte for another target");
			stop_cond();
			expect_byte("led", led, led_exp);

			// read twice with an ACK after the first byte and a NACK after the second
			start_cond();
			write_byte({TARGET_ADDR, 1'b1}, acked);
			expect_ack(acked, 1'b1, "its read address");
			read_byte(1'b1, got);
			expect_byte("read data", got, led_exp);
			read_byte(1'b0, got);
			expect_byte("repeated read data", got, led_exp);
			expect_byte("sda_drive_low", {7'b0, sda_drive_low}, 8'h00);
			stop_cond();

			// write one byte and then a repeated start and a read of it
			start_cond();
			write_byte({TARGET_ADDR, 1'b0}, acked);
			expect_ack(acked, 1'b1, "its write address");
			take_bits(8, r);
			led_exp = r[7:0];
			write_byte(led_exp, acked);
			expect_ack(acked, 1'b1, "a write data byte");
			start_cond();
			write_byte({TARGET_ADDR, 1'b1}, acked);
			expect_ack(acked, 1'b1, "its read address after a repeated start");
			read_byte(1'b0, got);
			expect_byte("read data after repeated start", got, led_exp);
			stop_cond();
		end

		quiet_bus <= 1'b1;
		glitch_idle(8);
		quiet_bus <= 1'b0;
		expect_byte("led", led, led_exp);

		if (dut0.asserts0.failed) begin
			abort_run("a protocol assertion failed before the end of the run");
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

//--- i2c_led.f
logic/i2c_led_pkg.sv
logic/line_filter.sv
logic/bus_event_decode.sv
logic/i2c_target_fsm.sv
logic/i2c_led_top.sv
tests/i2c_led_asserts.sv
tests/i2c_led_tb.sv

//--- Makefile
# Verilator flow for the I2C LED target

TB = i2c_led_tb

.PHONY: all lint sim clean

all: sim

# lint the synthesizable design on its own
lint:
	verilator --lint-only -Wall --top-module i2c_led_top \
		logic/i2c_led_pkg.sv logic/line_filter.sv logic/bus_event_decode.sv \
		logic/i2c_target_fsm.sv logic/i2c_led_top.sv

# build and run the testbench, the pass line in the output decides the status
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TB) \
		-f i2c_led.f -Mdir obj_dir
	./obj_dir/V$(TB) +verilator+error+limit+100 | tee /dev/stderr | \
		grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
